// ==== source/uart_cmd_defines.svh ====
`ifndef UART_CMD_DEFINES_SVH
`define UART_CMD_DEFINES_SVH

// Clock cycles per UART bit. 16 keeps simulation short.
// Use 434 for 115200 baud from a 50 MHz clock.
`define UART_BIT_CYCLES 16

// Idle bit periods between the command byte and the data byte of a write.
`define UART_GAP_BITS 4

// Bit periods allowed for a reply frame to start after the command byte.
`define UART_REPLY_BITS 40

`endif

// ==== source/uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

  // Host command word. wr=1 writes data to addr, wr=0 reads addr.
  typedef struct packed {
    logic       wr;
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_t;

  // One received frame with its error flags.
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
  } uart_rx_frame_t;

  // Result of a read as seen by the host.
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       timeout;
  } uart_rsp_t;

endpackage

`default_nettype wire

// ==== source/uart_tx_frame.sv ====
`default_nettype none
`include "uart_cmd_defines.svh"

module uart_tx_frame (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_done
);

  localparam int BIT_CYCLES = `UART_BIT_CYCLES;
  localparam int CNT_W      = $clog2(BIT_CYCLES);

  logic             busy;
  logic [CNT_W-1:0] cnt;
  logic [3:0]       bit_idx;
  logic [7:0]       shift;
  logic             par_bit;
  logic             bit_end;

  // Bit index 0 is the start bit, 1 to 8 data, 9 parity, 10 stop.
  assign bit_end = (cnt == CNT_W'(BIT_CYCLES - 1));
  assign tx_done = busy && (bit_idx == 4'd10) && bit_end;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      tx      <= 1'b1;
      cnt     <= '0;
      bit_idx <= '0;
    end
    else if (!busy)
    begin
      if (tx_start)
      begin
        busy    <= 1'b1;
        tx      <= 1'b0;
        cnt     <= '0;
        bit_idx <= '0;
      end
    end
    else if (bit_end)
    begin
      cnt     <= '0;
      bit_idx <= bit_idx + 1'b1;
      // The level for the next bit is set at the end of the current one.
      case (bit_idx)
        4'd8:
        begin
          tx <= par_bit;
        end
        4'd9:
        begin
          tx <= 1'b1;
        end
        4'd10:
        begin
          busy <= 1'b0;
        end
        default:
        begin
          tx <= shift[0];
        end
      endcase
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

  // The even parity bit makes the count of ones in the frame even.
  always_ff @(posedge clk)
  begin
    if (tx_start && !busy)
    begin
      shift   <= tx_byte;
      par_bit <= ^tx_byte;
    end
    else if (busy && bit_end && (bit_idx < 4'd8))
    begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== source/uart_rx_frame.sv ====
`default_nettype none
`include "uart_cmd_defines.svh"

module uart_rx_frame (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         rx,
  output logic                         rx_vld,
  output uart_cmd_pkg::uart_rx_frame_t rx_frame
);

  localparam int BIT_CYCLES  = `UART_BIT_CYCLES;
  localparam int HALF_CYCLES = BIT_CYCLES / 2;
  localparam int CNT_W       = $clog2(BIT_CYCLES);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             busy;
  logic [CNT_W-1:0] cnt;
  logic [3:0]       bit_idx;
  logic [7:0]       shift;
  logic             par_bit;
  logic             start_edge;
  logic             sample;
  logic             bit_end;

  assign start_edge = rx_prev && !rx_sync;
  assign sample     = busy && (cnt == CNT_W'(HALF_CYCLES - 1));
  assign bit_end    = (cnt == CNT_W'(BIT_CYCLES - 1));

  // The line idles high, so the synchronizer starts high to avoid a false start edge.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
      busy    <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
      rx_vld  <= 1'b0;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      rx_vld  <= 1'b0;
      if (!busy)
      begin
        cnt     <= '0;
        bit_idx <= '0;
        if (start_edge)
        begin
          busy <= 1'b1;
        end
      end
      else
      begin
        cnt <= bit_end ? '0 : cnt + 1'b1;
        if (bit_end)
        begin
          bit_idx <= bit_idx + 1'b1;
        end
        if (sample && (bit_idx == 4'd0) && rx_sync)
        begin
          busy <= 1'b0;   // glitch, not a start bit
        end
        else if (sample && (bit_idx == 4'd10))
        begin
          // Stop bit sampled. Return to idle so the next start edge is seen.
          busy   <= 1'b0;
          rx_vld <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      case (bit_idx)
        4'd0:
        begin
        end
        4'd9:
        begin
          par_bit <= rx_sync;
        end
        4'd10:
        begin
          rx_frame.data       <= shift;
          rx_frame.parity_err <= par_bit ^ (^shift);
          rx_frame.frame_err  <= !rx_sync;
        end
        default:
        begin
          // Data arrives LSB first and shifts down from the top.
          shift <= {rx_sync, shift[7:1]};
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/uart_cmd_sequencer.sv ====
`default_nettype none
`include "uart_cmd_defines.svh"

module uart_cmd_sequencer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cmd_vld,
  input  uart_cmd_pkg::uart_cmd_t      cmd,
  output logic                         cmd_rdy,
  output logic                         tx_start,
  output logic [7:0]                   tx_byte,
  input  logic                         tx_done,
  input  logic                         rx_vld,
  input  uart_cmd_pkg::uart_rx_frame_t rx_frame,
  output logic                         rsp_vld,
  output uart_cmd_pkg::uart_rsp_t      rsp
);

  import uart_cmd_pkg::*;

  localparam int BIT_CYCLES   = `UART_BIT_CYCLES;
  localparam int GAP_CYCLES   = `UART_GAP_BITS * BIT_CYCLES;
  // A reply that starts at the limit still needs a whole frame before rx_vld.
  localparam int REPLY_CYCLES = (`UART_REPLY_BITS + 11) * BIT_CYCLES;
  localparam int MAX_CYCLES   = (GAP_CYCLES > REPLY_CYCLES) ? GAP_CYCLES : REPLY_CYCLES;
  localparam int CNT_W        = $clog2(MAX_CYCLES);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_CMD,
    S_GAP,
    S_SEND_DATA,
    S_WAIT_REPLY,
    S_RESPOND
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] cnt;
  uart_cmd_t        cmd_q;
  logic             accept;
  logic             gap_end;
  logic             reply_end;

  // The respond state lasts one cycle and already accepts the next command.
  assign cmd_rdy   = (state == S_IDLE) || (state == S_RESPOND);
  assign rsp_vld   = (state == S_RESPOND);
  assign accept    = cmd_rdy && cmd_vld;
  assign gap_end   = (cnt == CNT_W'(GAP_CYCLES - 1));
  assign reply_end = (cnt == CNT_W'(REPLY_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      cnt      <= '0;
      tx_start <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        S_IDLE, S_RESPOND:
        begin
          if (accept)
          begin
            state    <= S_SEND_CMD;
            tx_start <= 1'b1;
          end
          else
          begin
            state <= S_IDLE;
          end
        end
        S_SEND_CMD:
        begin
          if (tx_done)
          begin
            cnt   <= '0;
            state <= cmd_q.wr ? S_GAP : S_WAIT_REPLY;
          end
        end
        S_GAP:
        begin
          if (gap_end)
          begin
            tx_start <= 1'b1;
            state    <= S_SEND_DATA;
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        S_SEND_DATA:
        begin
          if (tx_done)
          begin
            state <= S_IDLE;
          end
        end
        S_WAIT_REPLY:
        begin
          if (rx_vld || reply_end)
          begin
            state <= S_RESPOND;
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd;
      tx_byte <= {cmd.wr, cmd.addr};
    end
    else if ((state == S_GAP) && gap_end)
    begin
      tx_byte <= cmd_q.data;
    end

    // A bad stop bit is folded into parity_err for the host.
    if ((state == S_WAIT_REPLY) && rx_vld)
    begin
      rsp.data       <= rx_frame.data;
      rsp.parity_err <= rx_frame.parity_err || rx_frame.frame_err;
      rsp.timeout    <= 1'b0;
    end
    else if ((state == S_WAIT_REPLY) && reply_end)
    begin
      rsp.data       <= '0;
      rsp.parity_err <= 1'b0;
      rsp.timeout    <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/uart_cmd_master.sv ====
`default_nettype none

module uart_cmd_master (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_vld,
  input  uart_cmd_pkg::uart_cmd_t cmd,
  output logic                    cmd_rdy,
  input  logic                    rx,
  output logic                    tx,
  output logic                    rsp_vld,
  output uart_cmd_pkg::uart_rsp_t rsp
);

  import uart_cmd_pkg::*;

  logic           tx_start;
  logic [7:0]     tx_byte;
  logic           tx_done;
  logic           rx_vld;
  uart_rx_frame_t rx_frame;

  uart_rx_frame rx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_vld   (rx_vld),
    .rx_frame (rx_frame)
  );

  uart_cmd_sequencer seq0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .cmd      (cmd),
    .cmd_rdy  (cmd_rdy),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .rx_vld   (rx_vld),
    .rx_frame (rx_frame),
    .rsp_vld  (rsp_vld),
    .rsp      (rsp)
  );

  uart_tx_frame tx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  // Reset is released on a falling edge, away from the active edge.
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/tb_uart_device.sv ====
`default_nettype none
`include "uart_cmd_defines.svh"

module tb_uart_device (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx,
  input  logic [1:0] mode,
  input  logic [7:0] reply_byte,
  output logic       rx,
  output logic       busy,
  output logic       frame_vld,
  output logic [7:0] frame_byte,
  output logic       frame_par_ok,
  output int         frame_start
);

  localparam int         BIT_CYCLES   = `UART_BIT_CYCLES;
  localparam logic [1:0] MODE_BAD_PAR = 2'd1;
  localparam logic [1:0] MODE_SILENT  = 2'd2;

  logic [10:0] bits;
  logic [10:0] reply_bits;
  logic        tx_prev;
  logic        data_next;
  int          cycle_cnt = 0;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // The line is watched on falling clock edges, so every sample sits between two DUT updates.
  initial
  begin
    rx           = 1'b1;
    busy         = 1'b0;
    frame_vld    = 1'b0;
    frame_byte   = 8'h00;
    frame_par_ok = 1'b0;
    frame_start  = 0;
    tx_prev      = 1'b1;
    data_next    = 1'b0;
    forever
    begin
      @(negedge clk);
      if (rst_n && tx_prev && !tx)
      begin
        busy        = 1'b1;
        frame_start = cycle_cnt;
        repeat (BIT_CYCLES / 2 - 1) @(negedge clk);
        for (int i = 0; i < 11; i++)
        begin
          bits[i] = tx;
          if (i < 10)
          begin
            repeat (BIT_CYCLES) @(negedge clk);
          end
        end
        frame_byte   = bits[8:1];
        frame_par_ok = (^bits[9:1]) == 1'b0;
        frame_vld    = 1'b1;
        @(negedge clk);
        frame_vld    = 1'b0;
        // A command byte with its top bit clear is a read and gets a reply.
        if (!data_next && !bits[8] && (mode != MODE_SILENT))
        begin
          reply_bits = {1'b1, (^reply_byte) ^ (mode == MODE_BAD_PAR), reply_byte, 1'b0};
          repeat (2 * BIT_CYCLES) @(negedge clk);
          for (int i = 0; i < 11; i++)
          begin
            rx = reply_bits[i];
            repeat (BIT_CYCLES) @(negedge clk);
          end
          rx = 1'b1;
        end
        // The frame after a write command carries its data byte.
        data_next = !data_next && bits[8];
        busy = 1'b0;
      end
      tx_prev = tx;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_uart_cmd_master.sv ====
`default_nettype none
`include "uart_cmd_defines.svh"

module tb_uart_cmd_master;

  import uart_cmd_pkg::*;

  localparam int         BIT_CYCLES   = `UART_BIT_CYCLES;
  localparam int         GAP_MIN      = (11 + `UART_GAP_BITS) * BIT_CYCLES;
  localparam int         ROW_LIMIT    = 100 * BIT_CYCLES;
  localparam int         NUM_ROWS     = 8;
  localparam logic [1:0] MODE_NORMAL  = 2'd0;
  localparam logic [1:0] MODE_BAD_PAR = 2'd1;
  localparam logic [1:0] MODE_SILENT  = 2'd2;

  typedef struct packed {
    uart_cmd_t  cmd;
    logic [1:0] mode;
    logic [7:0] reply;
    uart_rsp_t  exp_rsp;
    logic [1:0] frames;
  } test_row_t;

  logic        clk;
  logic        rst_n;
  logic        cmd_vld;
  uart_cmd_t   cmd;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic        rsp_vld;
  uart_rsp_t   rsp;
  logic [1:0]  dev_mode;
  logic [7:0]  dev_reply;
  logic        dev_busy;
  logic        frame_vld;
  logic [7:0]  frame_byte;
  logic        frame_par_ok;
  int          frame_start;

  test_row_t   rows [NUM_ROWS];
  int          row_cnt = 0;
  logic [31:0] lfsr_state = 32'hb3d1;
  logic [7:0]  log_byte [64];
  logic        log_par [64];
  int          log_start [64];
  int          log_cnt = 0;

  tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(16)) clk0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_master dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_vld (cmd_vld),
    .cmd     (cmd),
    .cmd_rdy (cmd_rdy),
    .rx      (rx),
    .tx      (tx),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  tb_uart_device dev0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .tx           (tx),
    .mode         (dev_mode),
    .reply_byte   (dev_reply),
    .rx           (rx),
    .busy         (dev_busy),
    .frame_vld    (frame_vld),
    .frame_byte   (frame_byte),
    .frame_par_ok (frame_par_ok),
    .frame_start  (frame_start)
  );

  always @(posedge clk)
  begin
    if (frame_vld)
    begin
      log_byte[log_cnt]  <= frame_byte;
      log_par[log_cnt]   <= frame_par_ok;
      log_start[log_cnt] <= frame_start;
      log_cnt            <= log_cnt + 1;
    end
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("FAIL %0t: %s: got %h, expected %h", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic check_rsp(input uart_rsp_t got, input uart_rsp_t exp, input string msg);
    if (got !== exp)
    begin
      $display("FAIL %0t: %s: got data %h par %b tmo %b, expected data %h par %b tmo %b",
               $time, msg, got.data, got.parity_err, got.timeout,
               exp.data, exp.parity_err, exp.timeout);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp)
    begin
      $display("FAIL %0t: %s: got %b, expected %b", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string msg);
    if (got != exp)
    begin
      $display("FAIL %0t: %s: got %0d, expected %0d", $time, msg, got, exp);
      abort_run();
    end
  endtask

  // Galois LFSR that steps once for every bit taken.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
    begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      b[i] = lfsr_state[0];
    end
  endtask

  task automatic add_row(input logic wr, input logic [6:0] addr, input logic [1:0] mode);
    test_row_t  r;
    logic [7:0] wdata;
    logic [7:0] reply;
    take_byte(wdata);
    take_byte(reply);
    r.cmd     = '{wr: wr, addr: addr, data: wdata};
    r.mode    = mode;
    r.reply   = reply;
    r.frames  = wr ? 2'd2 : 2'd1;
    r.exp_rsp = '{data: reply, parity_err: (mode == MODE_BAD_PAR), timeout: 1'b0};
    if (wr)
    begin
      r.exp_rsp = '0;
    end
    else if (mode == MODE_SILENT)
    begin
      r.exp_rsp = '{data: 8'h00, parity_err: 1'b0, timeout: 1'b1};
    end
    rows[row_cnt] = r;
    row_cnt++;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!cmd_rdy && (n < ROW_LIMIT))
    begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy)
    begin
      $display("The master never became ready for a new command.");
      abort_run();
    end
  endtask

  task automatic run_row(input test_row_t r);
    int        n;
    int        base;
    int        rsp_cnt;
    logic      done;
    uart_rsp_t got;
    wait_ready();
    base      = log_cnt;
    dev_mode  = r.mode;
    dev_reply = r.reply;
    cmd       = r.cmd;
    cmd_vld   = 1'b1;
    @(negedge clk);
    cmd_vld   = 1'b0;
    cmd       = uart_cmd_t'(~r.cmd);
    check_bit(cmd_rdy, 1'b0, "cmd_rdy after accept");
    n       = 0;
    rsp_cnt = 0;
    done    = 1'b0;
    got     = '0;
    // Extra cmd_vld pulses while busy must be ignored.
    while (!done && (n < ROW_LIMIT))
    begin
      cmd_vld = 1'b0;
      if (rsp_vld)
      begin
        rsp_cnt++;
        got = rsp;
      end
      if (cmd_rdy)
      begin
        done = 1'b1;
      end
      else
      begin
        cmd_vld = (n == 3) || (n == 40);
        @(negedge clk);
        n++;
      end
    end
    if (!done)
    begin
      $display("The command did not complete before the timeout.");
      abort_run();
    end
    check_count(rsp_cnt, r.cmd.wr ? 0 : 1, "rsp_vld pulses");
    if (!r.cmd.wr)
    begin
      check_rsp(got, r.exp_rsp, "read response");
    end
    n    = 0;
    done = 1'b0;
    while (!done && (n < ROW_LIMIT))
    begin
      @(negedge clk);
      check_bit(rsp_vld, 1'b0, "rsp_vld after completion");
      n++;
      done = !dev_busy && (n >= BIT_CYCLES);
    end
    if (!done)
    begin
      $display("The remote device did not return to idle.");
      abort_run();
    end
    check_count(log_cnt - base, r.frames, "frames at device");
    check_byte(log_byte[base], r.cmd[15:8], "command byte");
    check_bit(log_par[base], 1'b1, "command byte parity");
    if (r.cmd.wr)
    begin
      check_byte(log_byte[base + 1], r.cmd.data, "data byte");
      check_bit(log_par[base + 1], 1'b1, "data byte parity");
      check_bit((log_start[base + 1] - log_start[base]) >= GAP_MIN, 1'b1, "write gap");
    end
  endtask

  initial
  begin : main
    int n;
    cmd_vld   = 1'b0;
    cmd       = '0;
    dev_mode  = MODE_NORMAL;
    dev_reply = 8'h00;
    add_row(1'b1, 7'h15, MODE_NORMAL);
    add_row(1'b0, 7'h2a, MODE_NORMAL);
    add_row(1'b0, 7'h31, MODE_BAD_PAR);
    add_row(1'b0, 7'h07, MODE_SILENT);
    add_row(1'b1, 7'h7f, MODE_NORMAL);
    add_row(1'b0, 7'h40, MODE_NORMAL);
    add_row(1'b1, 7'h00, MODE_NORMAL);
    add_row(1'b0, 7'h55, MODE_BAD_PAR);
    n = 0;
    while (!rst_n && (n < 100))
    begin
      @(negedge clk);
      n++;
    end
    if (!rst_n)
    begin
      $display("Reset was never released.");
      abort_run();
    end
    for (int i = 0; i < 8; i++)
    begin
      check_bit(tx, 1'b1, "tx idle after reset");
      check_bit(cmd_rdy, 1'b1, "cmd_rdy after reset");
      check_bit(rsp_vld, 1'b0, "rsp_vld after reset");
      @(negedge clk);
    end
    for (int i = 0; i < row_cnt; i++)
    begin
      run_row(rows[i]);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/uart_cmd_pkg.sv
source/uart_tx_frame.sv
source/uart_rx_frame.sv
source/uart_cmd_sequencer.sv
source/uart_cmd_master.sv
tests/tb_clock_gen.sv
tests/tb_uart_device.sv
tests/tb_uart_cmd_master.sv
